//--- build.f
+incdir+hdl
hdl/regbank_pkg.sv
hdl/sync_fifo.sv
hdl/priority_regfile.sv
hdl/read_arbiter.sv
hdl/regbank_top.sv
verification/regbank_scoreboard.sv
verification/regbank_chk.sv
verification/tb_regbank.sv

//--- Makefile
# Verilator flow for the register bank testbench
TOP := tb_regbank

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- verification/tb_regbank.sv
// Top-level testbench that runs seeded random test phases against the register bank and reports
`timescale 1ns/1ps
`include "regbank_cfg.svh"

module tb_regbank;
    localparam int CLK_PERIOD   = 40;
    localparam int DRAIN_CYCLES = 50;
    // Reset, stimulus of all six tests and one drain allowance each
    localparam int TOTAL_CYCLES = 3 + 40 + 72 + 72 + 60 + 60 + 60 + 6 * DRAIN_CYCLES;
    localparam int RD_OFF  = 0;
    localparam int RD_RAND = 1;
    localparam int RD_SEQ  = 2;

    logic                                       clk;
    logic                                       rst_n;
    logic [`REGBANK_NUM_WR-1:0]                 we;
    regbank_pkg::wr_req_t [`REGBANK_NUM_WR-1:0] wr;
    logic [`REGBANK_NUM_RD-1:0]                 rd_req_valid;
    logic [`REGBANK_NUM_RD-1:0]                 rd_req_ready;
    regbank_pkg::rd_req_t [`REGBANK_NUM_RD-1:0] rd_req;
    logic [`REGBANK_NUM_RD-1:0]                 rd_rsp_valid;
    logic [`REGBANK_NUM_RD-1:0]                 rd_rsp_ready;
    regbank_pkg::rd_rsp_t [`REGBANK_NUM_RD-1:0] rd_rsp;
    int                                         err_count;
    int                                         pending;
    int                                         seed = 60;
    int                                         tests_run;
    int                                         tests_failed;
    regbank_pkg::addr_t                         next_addr [`REGBANK_NUM_RD];

    regbank_top i_regbank_top (.*);

    regbank_scoreboard i_regbank_scoreboard (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
    endfunction

    // Kinds: 0 idle, 1 one level anywhere, 2 several levels on one address, 3 one level high half
    task automatic drive_writes(input int kind);
        int                 lvl;
        regbank_pkg::addr_t shared;
        we     = '0;
        shared = regbank_pkg::addr_t'(rand_range(0, `REGBANK_REG_COUNT - 1));
        lvl    = rand_range(0, `REGBANK_NUM_WR - 1);
        for (int l = 0; l < `REGBANK_NUM_WR; l++) begin
            wr[l].addr = shared;
            wr[l].data = $random(seed);
        end
        case (kind)
            1: we[lvl] = 1'b1;
            2: we = `REGBANK_NUM_WR'($random(seed));
            3: begin
                we[lvl]      = 1'b1;
                wr[lvl].addr = regbank_pkg::addr_t'(rand_range(8, 15));
            end
            default: we = '0;
        endcase
    endtask

    task automatic run_cycles(input int n, input int wr_kind, input int rd_mode,
                              input int lo, input int hi, input bit bp);
        logic [`REGBANK_NUM_RD-1:0] xfer;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            xfer = rd_req_valid & rd_req_ready;
            @(posedge clk);
            #2;
            drive_writes(wr_kind);
            for (int c = 0; c < `REGBANK_NUM_RD; c++) begin
                rd_rsp_ready[c] = bp ? (rand_range(0, 1) != 0) : 1'b1;
                // A pending request stays put until it is taken
                if (xfer[c] || !rd_req_valid[c]) begin
                    rd_req_valid[c] = (rd_mode == RD_SEQ) ||
                                      (rd_mode == RD_RAND && rand_range(0, 1) != 0);
                    if (rd_mode == RD_SEQ) begin
                        rd_req[c].addr = next_addr[c];
                        next_addr[c]   = next_addr[c] + 1'b1;
                    end else begin
                        rd_req[c].addr = regbank_pkg::addr_t'(rand_range(lo, hi));
                    end
                end
            end
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        int cycles = 0;
        bit stuck;
        while ((pending != 0 || rd_req_valid != '0) && cycles < DRAIN_CYCLES) begin
            run_cycles(1, 0, RD_OFF, 0, 0, 1'b0);
            cycles++;
        end
        stuck = (pending != 0) || (rd_req_valid != '0);
        if (stuck) begin
            $display("%s: reads still unanswered after %0d drain cycles", name, DRAIN_CYCLES);
        end
        tests_run++;
        if (stuck || err_count != err_before) begin
            tests_failed++;
            $display("test %-16s failed with %0d mismatches", name, err_count - err_before);
        end else begin
            $display("test %-16s ok", name);
        end
    endtask

    initial begin
        int err_before;
        rst_n        = 1'b0;
        we           = '0;
        wr           = '0;
        rd_req_valid = '0;
        rd_req       = '0;
        rd_rsp_ready = '1;
        tests_run    = 0;
        tests_failed = 0;
        for (int c = 0; c < `REGBANK_NUM_RD; c++) begin
            next_addr[c] = '0;
        end
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;

        err_before = err_count;
        run_cycles(40, 0, RD_SEQ, 0, 15, 1'b0);
        end_test("reset_values", err_before);

        err_before = err_count;
        run_cycles(30, 1, RD_OFF, 0, 0, 1'b0);
        run_cycles(2, 0, RD_OFF, 0, 0, 1'b0);
        run_cycles(40, 0, RD_RAND, 0, 15, 1'b0);
        end_test("write_then_read", err_before);

        err_before = err_count;
        run_cycles(30, 2, RD_OFF, 0, 0, 1'b0);
        run_cycles(2, 0, RD_OFF, 0, 0, 1'b0);
        run_cycles(40, 0, RD_RAND, 0, 15, 1'b0);
        end_test("write_priority", err_before);

        err_before = err_count;
        run_cycles(60, 0, RD_RAND, 0, 15, 1'b0);
        end_test("read_ordering", err_before);

        err_before = err_count;
        run_cycles(60, 0, RD_RAND, 0, 15, 1'b1);
        end_test("back_pressure", err_before);

        err_before = err_count;
        run_cycles(60, 3, RD_RAND, 0, 7, 1'b0);
        end_test("concurrent", err_before);

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Twice the cycle budget of all tests
    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles and the tests did not finish", 2 * TOTAL_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- verification/regbank_chk.sv
// Concurrent assertions that bind attaches to each read_arbiter to check grants and response credits
`timescale 1ns/1ps
`include "regbank_cfg.svh"

module regbank_chk #(
    parameter int NUM_READERS = `REGBANK_NUM_RD
) (
    input logic                                  clk,
    input logic                                  rst_n,
    input logic [NUM_READERS-1:0]                req_valid,
    input logic [NUM_READERS-1:0]                req_pop,
    input logic [NUM_READERS-1:0]                rsp_push,
    input regbank_pkg::count_t [NUM_READERS-1:0] rsp_count
);
    // At most one client wins per cycle
    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(req_pop))
        else $error("more than one read client granted in the same cycle");

    grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        (req_pop & ~req_valid) == '0)
        else $error("read grant given to a client with an empty request queue");

    // Credit check must keep every response push out of a full queue
    for (genvar c = 0; c < NUM_READERS; c++) begin : g_credit
        no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_push[c] |-> (int'(rsp_count[c]) < `REGBANK_FIFO_DEPTH))
            else $error("response pushed into the full queue of client %0d", c);
    end

endmodule

bind read_arbiter regbank_chk #(.NUM_READERS(NUM_READERS)) i_regbank_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_pop   (req_pop),
    .rsp_push  (rsp_push),
    .rsp_count (rsp_count)
);

//--- verification/regbank_scoreboard.sv
// Testbench monitor that models the register bank from its ports and counts response mismatches
`timescale 1ns/1ps
`include "regbank_cfg.svh"

module regbank_scoreboard (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [`REGBANK_NUM_WR-1:0]                 we,
    input  regbank_pkg::wr_req_t [`REGBANK_NUM_WR-1:0] wr,
    input  logic [`REGBANK_NUM_RD-1:0]                 rd_req_valid,
    input  logic [`REGBANK_NUM_RD-1:0]                 rd_req_ready,
    input  regbank_pkg::rd_req_t [`REGBANK_NUM_RD-1:0] rd_req,
    input  logic [`REGBANK_NUM_RD-1:0]                 rd_rsp_valid,
    input  logic [`REGBANK_NUM_RD-1:0]                 rd_rsp_ready,
    input  regbank_pkg::rd_rsp_t [`REGBANK_NUM_RD-1:0] rd_rsp,
    output int                                         err_count,
    output int                                         pending
);
    regbank_pkg::data_t shadow [`REGBANK_REG_COUNT];
    regbank_pkg::addr_t exp_q [`REGBANK_NUM_RD][$];
    logic               seen_req;

    always @(posedge clk or negedge rst_n) begin
        regbank_pkg::addr_t exp_addr;
        if (!rst_n) begin
            for (int r = 0; r < `REGBANK_REG_COUNT; r++) begin
                shadow[r] = '0;
            end
            for (int c = 0; c < `REGBANK_NUM_RD; c++) begin
                exp_q[c].delete();
            end
            err_count = 0;
            pending   = 0;
            seen_req  = 1'b0;
        end else begin
            // Idle state until the first request shows up
            if (!seen_req && rd_req_ready !== '1) begin
                $display("[FAIL] %0t rd_req_ready expected %b got %b", $time, 2'b11, rd_req_ready);
                err_count++;
            end
            if (!seen_req && rd_rsp_valid !== '0) begin
                $display("[FAIL] %0t rd_rsp_valid expected %b got %b", $time, 2'b00, rd_rsp_valid);
                err_count++;
            end
            if (rd_req_valid != '0) begin
                seen_req = 1'b1;
            end
            for (int c = 0; c < `REGBANK_NUM_RD; c++) begin
                if (rd_rsp_valid[c] && rd_rsp_ready[c]) begin
                    if (exp_q[c].size() == 0) begin
                        $display("%0t: client %0d got a response it never asked for", $time, c);
                        err_count++;
                    end else begin
                        exp_addr = exp_q[c].pop_front();
                        if (rd_rsp[c].addr !== exp_addr) begin
                            $display("[FAIL] %0t rd_rsp[%0d].addr expected %h got %h",
                                     $time, c, exp_addr, rd_rsp[c].addr);
                            err_count++;
                        end
                        if (rd_rsp[c].data !== shadow[exp_addr]) begin
                            $display("[FAIL] %0t rd_rsp[%0d].data expected %h got %h",
                                     $time, c, shadow[exp_addr], rd_rsp[c].data);
                            err_count++;
                        end
                    end
                end
                if (rd_req_valid[c] && rd_req_ready[c]) begin
                    exp_q[c].push_back(rd_req[c].addr);
                end
            end
            // Level 0 applied last so it wins a shared address
            for (int l = `REGBANK_NUM_WR - 1; l >= 0; l--) begin
                if (we[l]) begin
                    shadow[wr[l].addr] = wr[l].data;
                end
            end
            pending = 0;
            for (int c = 0; c < `REGBANK_NUM_RD; c++) begin
                pending += exp_q[c].size();
            end
        end
    end

endmodule

//--- hdl/regbank_top.sv
// Register bank top level joining write ports, per-client read queues, read arbiter and register file
`timescale 1ns/1ps
`include "regbank_cfg.svh"

module regbank_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [`REGBANK_NUM_WR-1:0]                 we,
    input  regbank_pkg::wr_req_t [`REGBANK_NUM_WR-1:0] wr,
    input  logic [`REGBANK_NUM_RD-1:0]                 rd_req_valid,
    output logic [`REGBANK_NUM_RD-1:0]                 rd_req_ready,
    input  regbank_pkg::rd_req_t [`REGBANK_NUM_RD-1:0] rd_req,
    output logic [`REGBANK_NUM_RD-1:0]                 rd_rsp_valid,
    input  logic [`REGBANK_NUM_RD-1:0]                 rd_rsp_ready,
    output regbank_pkg::rd_rsp_t [`REGBANK_NUM_RD-1:0] rd_rsp
);
    // Request side
    logic [`REGBANK_NUM_RD-1:0]                 req_full;
    logic [`REGBANK_NUM_RD-1:0]                 req_empty;
    logic [`REGBANK_NUM_RD-1:0]                 req_pop;
    regbank_pkg::rd_req_t [`REGBANK_NUM_RD-1:0] req_head;

    // Response side
    logic [`REGBANK_NUM_RD-1:0]                rsp_empty;
    logic [`REGBANK_NUM_RD-1:0]                rsp_push;
    regbank_pkg::count_t [`REGBANK_NUM_RD-1:0] rsp_count;
    regbank_pkg::rd_rsp_t                      rsp_data;

    // Register file read port
    regbank_pkg::addr_t raddr;
    regbank_pkg::data_t rdata;

    assign rd_req_ready = ~req_full;
    assign rd_rsp_valid = ~rsp_empty;

    for (genvar c = 0; c < `REGBANK_NUM_RD; c++) begin : g_client
        sync_fifo #(
            .item_t (regbank_pkg::rd_req_t),
            .DEPTH  (`REGBANK_FIFO_DEPTH)
        ) i_req_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (rd_req_valid[c]),
            .push_data (rd_req[c]),
            .full      (req_full[c]),
            .pop       (req_pop[c]),
            .pop_data  (req_head[c]),
            .empty     (req_empty[c]),
            .count     ()
        );

        sync_fifo #(
            .item_t (regbank_pkg::rd_rsp_t),
            .DEPTH  (`REGBANK_FIFO_DEPTH)
        ) i_rsp_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (rsp_push[c]),
            .push_data (rsp_data),
            .full      (),
            .pop       (rd_rsp_ready[c]),
            .pop_data  (rd_rsp[c]),
            .empty     (rsp_empty[c]),
            .count     (rsp_count[c])
        );
    end

    read_arbiter #(
        .NUM_READERS (`REGBANK_NUM_RD)
    ) i_read_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (~req_empty),
        .req       (req_head),
        .req_pop   (req_pop),
        .rsp_count (rsp_count),
        .rsp_push  (rsp_push),
        .rsp       (rsp_data),
        .raddr     (raddr),
        .rdata     (rdata)
    );

    priority_regfile #(
        .NUM_PRIORITY_LEVELS (`REGBANK_NUM_WR)
    ) i_priority_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (we),
        .wr    (wr),
        .raddr (raddr),
        .rdata (rdata)
    );

endmodule

//--- hdl/read_arbiter.sv
// Round-robin read arbiter with response-queue credit checks, tracks reads through the register file
`timescale 1ns/1ps
`include "regbank_cfg.svh"

module read_arbiter #(
    parameter int NUM_READERS = `REGBANK_NUM_RD
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [NUM_READERS-1:0]                 req_valid,
    input  regbank_pkg::rd_req_t [NUM_READERS-1:0] req,
    output logic [NUM_READERS-1:0]                 req_pop,
    input  regbank_pkg::count_t [NUM_READERS-1:0]  rsp_count,
    output logic [NUM_READERS-1:0]                 rsp_push,
    output regbank_pkg::rd_rsp_t                   rsp,
    output regbank_pkg::addr_t                     raddr,
    input  regbank_pkg::data_t                     rdata
);
    // One read travelling down the register file pipeline
    typedef struct packed {
        logic                    valid;
        regbank_pkg::client_id_t id;
        regbank_pkg::addr_t      addr;
    } rd_tag_t;

    regbank_pkg::client_id_t              rr_ptr;
    regbank_pkg::client_id_t              grant_id;
    logic                                 grant_any;
    logic [NUM_READERS-1:0]               eligible;
    regbank_pkg::count_t [NUM_READERS-1:0] inflight;
    rd_tag_t                              tag_s1;
    rd_tag_t                              tag_s2;

    // Client may go only if its response queue can absorb every outstanding read
    always_comb begin
        for (int c = 0; c < NUM_READERS; c++) begin
            eligible[c] = req_valid[c] &&
                ((int'(rsp_count[c]) + int'(inflight[c])) < `REGBANK_FIFO_DEPTH);
        end
    end

    // First eligible client at or after the rotating pointer
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_id  = rr_ptr;
        for (int k = 0; k < NUM_READERS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_READERS;
            if (!grant_any && eligible[idx]) begin
                grant_any = 1'b1;
                grant_id  = regbank_pkg::client_id_t'(idx);
            end
        end
    end

    // Grant doubles as the request queue pop
    always_comb begin
        req_pop = '0;
        if (grant_any) begin
            req_pop[grant_id] = 1'b1;
        end
    end

    // Address reaches the register file in the grant cycle
    assign raddr = req[grant_id].addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (grant_any) begin
            rr_ptr <= regbank_pkg::client_id_t'((int'(grant_id) + 1) % NUM_READERS);
        end
    end

    // Tags line up with the two register file stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_s1 <= '0;
            tag_s2 <= '0;
        end else begin
            tag_s1.valid <= grant_any;
            tag_s1.id    <= grant_id;
            tag_s1.addr  <= raddr;
            tag_s2       <= tag_s1;
        end
    end

    // Outstanding reads per client
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inflight <= '0;
        end else begin
            for (int c = 0; c < NUM_READERS; c++) begin
                case ({req_pop[c], rsp_push[c]})
                    2'b10:   inflight[c] <= inflight[c] + 1'b1;
                    2'b01:   inflight[c] <= inflight[c] - 1'b1;
                    default: inflight[c] <= inflight[c];
                endcase
            end
        end
    end

    // Returning data goes to the queue of the client that asked
    always_comb begin
        for (int c = 0; c < NUM_READERS; c++) begin
            rsp_push[c] = tag_s2.valid && (tag_s2.id == regbank_pkg::client_id_t'(c));
        end
    end

    assign rsp.addr = tag_s2.addr;
    assign rsp.data = rdata;

endmodule

//--- hdl/priority_regfile.sv
// Two-stage register file with prioritized write levels and one pipelined read port
`timescale 1ns/1ps
`include "regbank_cfg.svh"

module priority_regfile #(
    parameter int NUM_PRIORITY_LEVELS = `REGBANK_NUM_WR
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic [NUM_PRIORITY_LEVELS-1:0]                 we,
    input  regbank_pkg::wr_req_t [NUM_PRIORITY_LEVELS-1:0] wr,
    input  regbank_pkg::addr_t                             raddr,
    output regbank_pkg::data_t                             rdata
);
    localparam int REG_COUNT = `REGBANK_REG_COUNT;

    regbank_pkg::data_t regs [REG_COUNT];

    // First stage registers
    logic [NUM_PRIORITY_LEVELS-1:0]                 we_q;
    regbank_pkg::wr_req_t [NUM_PRIORITY_LEVELS-1:0] wr_q;
    regbank_pkg::data_t                             rdata_q1;

    // Second stage output
    regbank_pkg::data_t rdata_q2;

    // Levels that survive the address conflict check
    logic [NUM_PRIORITY_LEVELS-1:0] wr_win;

    // Capture write requests and read the array
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q     <= '0;
            wr_q     <= '0;
            rdata_q1 <= '0;
        end else begin
            we_q     <= we;
            wr_q     <= wr;
            rdata_q1 <= regs[raddr];
        end
    end

    // A level loses when any lower-numbered active level hits the same address
    always_comb begin
        for (int lvl = 0; lvl < NUM_PRIORITY_LEVELS; lvl++) begin
            wr_win[lvl] = we_q[lvl];
            for (int hi = 0; hi < lvl; hi++) begin
                if (we_q[hi] && (wr_q[hi].addr == wr_q[lvl].addr)) begin
                    wr_win[lvl] = 1'b0;
                end
            end
        end
    end

    // Commit winning writes, forward read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q2 <= '0;
            for (int r = 0; r < REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            rdata_q2 <= rdata_q1;
            for (int lvl = 0; lvl < NUM_PRIORITY_LEVELS; lvl++) begin
                if (wr_win[lvl]) begin
                    regs[wr_q[lvl].addr] <= wr_q[lvl].data;
                end
            end
        end
    end

    assign rdata = rdata_q2;

endmodule

//--- hdl/sync_fifo.sv
// Synchronous circular-buffer FIFO with a type parameter payload, used for read requests and responses
`timescale 1ns/1ps
`include "regbank_cfg.svh"

module sync_fifo #(
    parameter type item_t = logic [`REGBANK_DWIDTH-1:0],
    parameter int  DEPTH  = `REGBANK_FIFO_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  item_t                      push_data,
    output logic                       full,
    input  logic                       pop,
    output item_t                      pop_data,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] count
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    // Flags follow the registered count
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/regbank_pkg.sv
// Shared struct and scalar types for the register bank RTL and its testbench
`include "regbank_cfg.svh"

package regbank_pkg;

    // Scalar building blocks
    typedef logic [`REGBANK_AWIDTH-1:0] addr_t;
    typedef logic [`REGBANK_DWIDTH-1:0] data_t;

    // Read client index
    typedef logic [$clog2(`REGBANK_NUM_RD)-1:0] client_id_t;

    // Occupancy of a request or response queue
    typedef logic [$clog2(`REGBANK_FIFO_DEPTH+1)-1:0] count_t;

    // One write level, enable travels separately
    typedef struct packed {
        addr_t addr;
        data_t data;
    } wr_req_t;

    // Read request from a client
    typedef struct packed {
        addr_t addr;
    } rd_req_t;

    // Read answer, address echoed for matching
    typedef struct packed {
        addr_t addr;
        data_t data;
    } rd_rsp_t;

endpackage

//--- hdl/regbank_cfg.svh
// Width, port count and queue depth macros for the register bank, included by package and RTL
`ifndef REGBANK_CFG_SVH
`define REGBANK_CFG_SVH

// Register data and address widths
`define REGBANK_DWIDTH 32
`define REGBANK_AWIDTH 4

// Number of addressable registers
`define REGBANK_REG_COUNT (1 << `REGBANK_AWIDTH)

// Write priority levels, level 0 is the strongest
`define REGBANK_NUM_WR 3

// Read clients sharing the single read port
`define REGBANK_NUM_RD 2

// Entries in every request and response queue
`define REGBANK_FIFO_DEPTH 4

`endif
